// ==== rtl/exu_pkg.sv ====
package exu_pkg;

    localparam int XLEN      = 64;
    localparam int REG_COUNT = 32;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [31:0]     word_t;
    typedef logic [4:0]      reg_idx_t;
    typedef logic [7:0]      byte_mask_t;

    // one entry per supported instruction
    typedef enum logic [5:0] {
        ADD, SUB, SLL, SRL, SRA, AND, OR, XOR, SLT, SLTU,
        ADDW, SUBW, SLLW, SRLW, SRAW,
        MUL, MULW, DIVU, REMU, DIVW, REMW,
        LUI, AUIPC,
        JAL, JALR,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        LB, LBU, LH, LHU, LW, LWU, LD,
        SB, SH, SW, SD
    } exec_op_t;

    typedef struct packed {
        exec_op_t op;
        // second operand taken from imm
        logic     use_imm;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        xlen_t    imm;
        xlen_t    pc;
    } exec_inst_t;

    typedef struct packed {
        logic       read_en;
        logic       write_en;
        xlen_t      addr;
        xlen_t      wdata;
        byte_mask_t wmask;
    } mem_req_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        logic     wen;
        xlen_t    data;
        xlen_t    pc;
        xlen_t    next_pc;
    } retire_t;

    // word results are widened from bit 31
    function automatic xlen_t sext_word(input word_t w);
        return {{(XLEN - 32){w[31]}}, w};
    endfunction

endpackage

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ps

module reg_file
    import exu_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    output xlen_t    rs1_data,
    output xlen_t    rs2_data,
    input  logic     wen,
    input  reg_idx_t rd,
    input  xlen_t    wdata
);

    xlen_t regs [REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

    // x0 stays zero across every write the stage makes
    x0_zero: assert property (
        @(posedge clk) disable iff (reset)
        regs[0] == '0
    ) else $error("register x0 holds %h", regs[0]);

endmodule

// ==== rtl/int_alu.sv ====
`timescale 1ns/1ps

module int_alu
    import exu_pkg::*;
(
    input  exec_inst_t inst,
    input  xlen_t      rs1_data,
    input  xlen_t      rs2_data,
    output xlen_t      alu_result,
    output logic       cmp_eq,
    output logic       cmp_lt,
    output logic       cmp_ltu
);

    logic       imm_forced;
    xlen_t      op_a;
    xlen_t      op_b;
    xlen_t      sum;
    xlen_t      diff;
    logic [5:0] shamt;
    logic [4:0] shamt_w;
    word_t      a_w;

    // address and target forms always add the immediate
    assign imm_forced = inst.op inside {LB, LBU, LH, LHU, LW, LWU, LD,
                                        SB, SH, SW, SD, JAL, JALR, AUIPC};

    assign op_a = (inst.op == AUIPC || inst.op == JAL) ? inst.pc : rs1_data;
    assign op_b = (inst.use_imm || imm_forced) ? inst.imm : rs2_data;

    assign sum     = op_a + op_b;
    assign diff    = op_a - op_b;
    assign shamt   = op_b[5:0];
    assign shamt_w = op_b[4:0];
    assign a_w     = op_a[31:0];

    always_comb begin
        case (inst.op)
            ADD, AUIPC, JAL, JALR,
            LB, LBU, LH, LHU, LW, LWU, LD,
            SB, SH, SW, SD: alu_result = sum;
            SUB:  alu_result = diff;
            SLL:  alu_result = op_a << shamt;
            SRL:  alu_result = op_a >> shamt;
            SRA:  alu_result = $signed(op_a) >>> shamt;
            AND:  alu_result = op_a & op_b;
            OR:   alu_result = op_a | op_b;
            XOR:  alu_result = op_a ^ op_b;
            SLT:  alu_result = {{(XLEN - 1){1'b0}}, $signed(op_a) < $signed(op_b)};
            SLTU: alu_result = {{(XLEN - 1){1'b0}}, op_a < op_b};
            ADDW: alu_result = sext_word(sum[31:0]);
            SUBW: alu_result = sext_word(diff[31:0]);
            SLLW: alu_result = sext_word(a_w << shamt_w);
            SRLW: alu_result = sext_word(a_w >> shamt_w);
            SRAW: alu_result = sext_word($signed(a_w) >>> shamt_w);
            default: alu_result = '0;
        endcase
    end

    // branch compares always see the two registers
    assign cmp_eq  = (rs1_data == rs2_data);
    assign cmp_lt  = ($signed(rs1_data) < $signed(rs2_data));
    assign cmp_ltu = (rs1_data < rs2_data);

endmodule

// ==== rtl/mul_div_unit.sv ====
`timescale 1ns/1ps

module mul_div_unit
    import exu_pkg::*;
(
    input  exec_op_t op,
    input  xlen_t    rs1_data,
    input  xlen_t    rs2_data,
    output xlen_t    md_result
);

    word_t a_w;
    word_t b_w;
    xlen_t product;
    word_t product_w;
    xlen_t quot;
    xlen_t rem;
    word_t quot_w;
    word_t rem_w;
    logic  overflow_w;

    assign a_w        = rs1_data[31:0];
    assign b_w        = rs2_data[31:0];
    assign product    = rs1_data * rs2_data;
    assign product_w  = a_w * b_w;
    assign overflow_w = (a_w == 32'h8000_0000) && (b_w == 32'hffff_ffff);

    always_comb begin
        if (rs2_data == '0) begin
            quot = '1;
            rem  = rs1_data;
        end else begin
            quot = rs1_data / rs2_data;
            rem  = rs1_data % rs2_data;
        end
    end

    // signed word divide with the zero and overflow cases
    always_comb begin
        if (b_w == '0) begin
            quot_w = '1;
            rem_w  = a_w;
        end else if (overflow_w) begin
            quot_w = a_w;
            rem_w  = '0;
        end else begin
            quot_w = $signed(a_w) / $signed(b_w);
            rem_w  = $signed(a_w) % $signed(b_w);
        end
    end

    always_comb begin
        case (op)
            MUL:     md_result = product;
            MULW:    md_result = sext_word(product_w);
            DIVU:    md_result = quot;
            REMU:    md_result = rem;
            DIVW:    md_result = sext_word(quot_w);
            REMW:    md_result = sext_word(rem_w);
            default: md_result = '0;
        endcase
    end

endmodule

// ==== rtl/load_store_unit.sv ====
`timescale 1ns/1ps

module load_store_unit
    import exu_pkg::*;
(
    input  logic     inst_valid,
    input  exec_op_t op,
    input  xlen_t    addr,
    input  xlen_t    rs2_data,
    input  xlen_t    mem_rdata,
    output mem_req_t mem_req,
    output xlen_t    load_data
);

    logic        is_load;
    logic        is_store;
    byte_mask_t  size_mask;
    logic [15:0] lane_mask;
    logic [5:0]  lane_shift;
    xlen_t       rdata_lanes;

    assign is_load  = op inside {LB, LBU, LH, LHU, LW, LWU, LD};
    assign is_store = op inside {SB, SH, SW, SD};

    // access width as a mask at lane 0
    always_comb begin
        case (op)
            LB, LBU, SB: size_mask = 8'h01;
            LH, LHU, SH: size_mask = 8'h03;
            LW, LWU, SW: size_mask = 8'h0f;
            LD, SD:      size_mask = 8'hff;
            default:     size_mask = 8'h00;
        endcase
    end

    // upper byte of lane_mask catches a doubleword crossing
    assign lane_mask  = {8'h00, size_mask} << addr[2:0];
    assign lane_shift = {addr[2:0], 3'b000};

    always_comb begin
        mem_req.read_en  = inst_valid && is_load;
        mem_req.write_en = inst_valid && is_store;
        mem_req.addr     = addr;
        mem_req.wdata    = rs2_data << lane_shift;
        mem_req.wmask    = is_store ? lane_mask[7:0] : '0;
    end

    assign rdata_lanes = mem_rdata >> lane_shift;

    always_comb begin
        case (op)
            LB:      load_data = {{(XLEN - 8){rdata_lanes[7]}}, rdata_lanes[7:0]};
            LBU:     load_data = {{(XLEN - 8){1'b0}}, rdata_lanes[7:0]};
            LH:      load_data = {{(XLEN - 16){rdata_lanes[15]}}, rdata_lanes[15:0]};
            LHU:     load_data = {{(XLEN - 16){1'b0}}, rdata_lanes[15:0]};
            LW:      load_data = sext_word(rdata_lanes[31:0]);
            LWU:     load_data = {{(XLEN - 32){1'b0}}, rdata_lanes[31:0]};
            LD:      load_data = rdata_lanes;
            default: load_data = '0;
        endcase
    end

    // every accessed byte stays inside one aligned doubleword
    always_comb begin
        if (inst_valid && (is_load || is_store)) begin
            in_dword: assert final (lane_mask[15:8] == 8'h00)
                else $error("access at %h leaves the aligned doubleword", addr);
        end
    end

endmodule

// ==== rtl/result_select.sv ====
`timescale 1ns/1ps

module result_select
    import exu_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       inst_valid,
    input  exec_inst_t inst,
    input  xlen_t      alu_result,
    input  xlen_t      md_result,
    input  xlen_t      load_data,
    input  logic       cmp_eq,
    input  logic       cmp_lt,
    input  logic       cmp_ltu,
    output logic       wen,
    output xlen_t      wdata,
    output xlen_t      next_pc,
    output retire_t    retire
);

    xlen_t pc_plus4;
    xlen_t branch_target;
    logic  is_branch;
    logic  taken;
    logic  writes_rd;

    assign pc_plus4      = inst.pc + 64'd4;
    assign branch_target = inst.pc + inst.imm;
    assign is_branch     = inst.op inside {BEQ, BNE, BLT, BGE, BLTU, BGEU};
    assign writes_rd     = !is_branch && !(inst.op inside {SB, SH, SW, SD});

    always_comb begin
        case (inst.op)
            BEQ:     taken = cmp_eq;
            BNE:     taken = !cmp_eq;
            BLT:     taken = cmp_lt;
            BGE:     taken = !cmp_lt;
            BLTU:    taken = cmp_ltu;
            BGEU:    taken = !cmp_ltu;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        if (is_branch) begin
            next_pc = taken ? branch_target : pc_plus4;
        end else if (inst.op == JAL) begin
            next_pc = alu_result;
        end else if (inst.op == JALR) begin
            next_pc = {alu_result[XLEN-1:1], 1'b0};
        end else begin
            next_pc = pc_plus4;
        end
    end

    always_comb begin
        case (inst.op)
            MUL, MULW, DIVU, REMU, DIVW, REMW: wdata = md_result;
            LB, LBU, LH, LHU, LW, LWU, LD:     wdata = load_data;
            JAL, JALR:                         wdata = pc_plus4;
            LUI:                               wdata = inst.imm;
            default:                           wdata = alu_result;
        endcase
    end

    assign wen = inst_valid && writes_rd && (inst.rd != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            retire.valid <= 1'b0;
        end else begin
            retire.valid <= inst_valid;
            if (inst_valid) begin
                retire.rd      <= inst.rd;
                retire.wen     <= wen;
                retire.data    <= wdata;
                retire.pc      <= inst.pc;
                retire.next_pc <= next_pc;
            end
        end
    end

    // a retire pulse needs an accepted instruction one cycle earlier
    retire_after_issue: assert property (
        @(posedge clk) disable iff (reset)
        !inst_valid |=> !retire.valid
    ) else $error("retire pulse without a valid instruction");

endmodule

// ==== rtl/exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit
    import exu_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       inst_valid,
    input  exec_inst_t inst,
    input  xlen_t      mem_rdata,
    output mem_req_t   mem_req,
    output xlen_t      next_pc,
    output retire_t    retire
);

    xlen_t rs1_data;
    xlen_t rs2_data;
    xlen_t alu_result;
    xlen_t md_result;
    xlen_t load_data;
    xlen_t wdata;
    logic  wen;
    logic  cmp_eq;
    logic  cmp_lt;
    logic  cmp_ltu;

    reg_file u_reg_file (
        .clk      (clk),
        .reset    (reset),
        .rs1      (inst.rs1),
        .rs2      (inst.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wen      (wen),
        .rd       (inst.rd),
        .wdata    (wdata)
    );

    int_alu u_int_alu (
        .inst       (inst),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .alu_result (alu_result),
        .cmp_eq     (cmp_eq),
        .cmp_lt     (cmp_lt),
        .cmp_ltu    (cmp_ltu)
    );

    mul_div_unit u_mul_div_unit (
        .op        (inst.op),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .md_result (md_result)
    );

    // the ALU sum doubles as the memory address
    load_store_unit u_load_store_unit (
        .inst_valid (inst_valid),
        .op         (inst.op),
        .addr       (alu_result),
        .rs2_data   (rs2_data),
        .mem_rdata  (mem_rdata),
        .mem_req    (mem_req),
        .load_data  (load_data)
    );

    result_select u_result_select (
        .clk        (clk),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst       (inst),
        .alu_result (alu_result),
        .md_result  (md_result),
        .load_data  (load_data),
        .cmp_eq     (cmp_eq),
        .cmp_lt     (cmp_lt),
        .cmp_ltu    (cmp_ltu),
        .wen        (wen),
        .wdata      (wdata),
        .next_pc    (next_pc),
        .retire     (retire)
    );

endmodule

// ==== tests/exec_unit_tests.svh ====
exec_op_t alu_ops [15] = '{ADD, SUB, SLL, SRL, SRA, AND, OR, XOR, SLT, SLTU,
                           ADDW, SUBW, SLLW, SRLW, SRAW};
exec_op_t md_ops [6] = '{MUL, MULW, DIVU, REMU, DIVW, REMW};
exec_op_t st_ops [4] = '{SB, SH, SW, SD};
exec_op_t ld_ops [7] = '{LB, LBU, LH, LHU, LW, LWU, LD};
int       ld_size [7] = '{1, 1, 2, 2, 4, 4, 8};
exec_op_t br_ops [6] = '{BEQ, BNE, BLT, BGE, BLTU, BGEU};

task automatic test_reset();
    int         errs;
    exec_inst_t i;
    mem_req_t   req;
    mem_req_t   exp;
    xlen_t      npc;
    retire_t    ret;
    errs = error_count;
    @(negedge clk);
    if (retire.valid !== 1'b0) begin
        error_count++;
        $display("ERROR %0t: retire valid high right after reset", $time);
    end
    i = make_inst(SD, 5'd0, 5'd0, 5'd7, 1'b0, 64'h80);
    run_inst(i, req, npc, ret);
    exp = '{read_en: 1'b0, write_en: 1'b1, addr: 64'h80, wdata: '0, wmask: 8'hff};
    check_mem_req("store of reset register", req, exp);
    i = make_inst(ADD, 5'd0, 5'd0, 5'd0, 1'b1, 64'd55);
    run_inst(i, req, npc, ret);
    check_retire("write to x0", ret, make_retire(i, 1'b0, 64'd55, i.pc + 4));
    i = make_inst(ADD, 5'd3, 5'd0, 5'd0, 1'b0, 64'd0);
    run_inst(i, req, npc, ret);
    check_retire("read of x0", ret, make_retire(i, 1'b1, 64'd0, i.pc + 4));
    finish_test("reset and x0", errs);
endtask

task automatic test_alu();
    int          errs;
    exec_inst_t  i;
    mem_req_t    req;
    xlen_t       npc;
    retire_t     ret;
    xlen_t       imm;
    logic [11:0] imm12;
    errs = error_count;
    for (int round = 0; round < 3; round++) begin
        set_reg(5'd1, rand64());
        set_reg(5'd2, rand64());
        foreach (alu_ops[k]) begin
            i = make_inst(alu_ops[k], 5'd3, 5'd1, 5'd2, 1'b0, '0);
            run_inst(i, req, npc, ret);
            check_retire("alu register form", ret, make_retire(i, 1'b1,
                         expect_result(alu_ops[k], model_regs[1], model_regs[2]), i.pc + 4));
        end
        imm12 = 12'($random(seed));
        imm   = {{52{imm12[11]}}, imm12};
        i = make_inst(ADDW, 5'd4, 5'd1, 5'd0, 1'b1, imm);
        run_inst(i, req, npc, ret);
        check_xlen("addiw", ret.data, expect_result(ADDW, model_regs[1], imm));
        i = make_inst(LUI, 5'd4, 5'd0, 5'd0, 1'b1, imm << 12);
        run_inst(i, req, npc, ret);
        check_xlen("lui", ret.data, imm << 12);
        i = make_inst(AUIPC, 5'd4, 5'd0, 5'd0, 1'b1, imm << 12);
        run_inst(i, req, npc, ret);
        check_xlen("auipc", ret.data, i.pc + (imm << 12));
    end
    finish_test("alu", errs);
endtask

task automatic test_mul_div();
    int         errs;
    exec_inst_t i;
    mem_req_t   req;
    xlen_t      npc;
    retire_t    ret;
    xlen_t      a;
    xlen_t      b;
    errs = error_count;
    for (int round = 0; round < 5; round++) begin
        a = rand64();
        b = (round == 3) ? '0 : rand64();
        if (round == 4) begin
            a = 64'hffff_ffff_8000_0000;
            b = '1;
        end
        set_reg(5'd1, a);
        set_reg(5'd2, b);
        foreach (md_ops[k]) begin
            i = make_inst(md_ops[k], 5'd3, 5'd1, 5'd2, 1'b0, '0);
            run_inst(i, req, npc, ret);
            check_xlen("mul/div result", ret.data, expect_result(md_ops[k], a, b));
        end
    end
    finish_test("mul/div", errs);
endtask

task automatic test_load_store();
    int         errs;
    int         sz;
    exec_inst_t i;
    mem_req_t   req;
    mem_req_t   exp;
    xlen_t      npc;
    retire_t    ret;
    xlen_t      ld_exp;
    errs = error_count;
    set_reg(5'd1, 64'h40);
    foreach (st_ops[k]) begin
        sz = 1 << k;
        for (int off = 0; off + sz <= 8; off++) begin
            set_reg(5'd2, rand64());
            i = make_inst(st_ops[k], 5'd0, 5'd1, 5'd2, 1'b0, 64'(off));
            run_inst(i, req, npc, ret);
            exp.read_en  = 1'b0;
            exp.write_en = 1'b1;
            exp.addr     = 64'h40 + off;
            exp.wdata    = model_regs[2] << (8 * off);
            exp.wmask    = 8'(((1 << sz) - 1) << off);
            check_mem_req("store request", req, exp);
        end
    end
    mem_words[16] = rand64();
    set_reg(5'd1, 64'h80);
    foreach (ld_ops[k]) begin
        for (int off = 0; off < 8; off += ld_size[k]) begin
            ld_exp = expect_load(ld_ops[k], 64'h80 + off);
            i = make_inst(ld_ops[k], 5'd5, 5'd1, 5'd0, 1'b0, 64'(off));
            run_inst(i, req, npc, ret);
            // rs2 is x0, so no store data rides along
            exp.read_en  = 1'b1;
            exp.write_en = 1'b0;
            exp.addr     = 64'h80 + off;
            exp.wdata    = '0;
            exp.wmask    = '0;
            check_mem_req("load request", req, exp);
            check_xlen("load data", ret.data, ld_exp);
        end
    end
    finish_test("load/store", errs);
endtask

task automatic test_branch_jump();
    int         errs;
    logic       cond;
    xlen_t      a;
    xlen_t      b;
    exec_inst_t i;
    mem_req_t   req;
    xlen_t      npc;
    retire_t    ret;
    errs = error_count;
    for (int p = 0; p < 4; p++) begin
        a = (p == 1) ? -64'sd3 : 64'd5 + p;
        b = (p == 0) ? 64'd5 : ((p == 2) ? -64'sd3 : 64'd9);
        set_reg(5'd1, a);
        set_reg(5'd2, b);
        foreach (br_ops[k]) begin
            case (br_ops[k])
                BEQ:     cond = (a == b);
                BNE:     cond = (a != b);
                BLT:     cond = ($signed(a) < $signed(b));
                BGE:     cond = ($signed(a) >= $signed(b));
                BLTU:    cond = (a < b);
                default: cond = (a >= b);
            endcase
            i = make_inst(br_ops[k], 5'd0, 5'd1, 5'd2, 1'b0, -64'sd64);
            run_inst(i, req, npc, ret);
            check_xlen("branch target", npc, cond ? i.pc - 64 : i.pc + 4);
        end
    end
    i = make_inst(JAL, 5'd4, 5'd0, 5'd0, 1'b1, 64'h100);
    run_inst(i, req, npc, ret);
    check_retire("jal", ret, make_retire(i, 1'b1, i.pc + 4, i.pc + 64'h100));
    set_reg(5'd1, 64'h2001);
    i = make_inst(JALR, 5'd4, 5'd1, 5'd0, 1'b1, 64'h4);
    run_inst(i, req, npc, ret);
    check_xlen("jalr target", npc, 64'h2004);
    check_retire("jalr", ret, make_retire(i, 1'b1, i.pc + 4, 64'h2004));
    finish_test("branch and jump", errs);
endtask

task automatic test_back_to_back();
    int         errs;
    exec_inst_t burst [4];
    errs = error_count;
    for (int k = 0; k < 4; k++) begin
        burst[k] = make_inst(ADD, reg_idx_t'(5 + k), 5'd0, 5'd0, 1'b1, 64'(100 + k));
        cur_pc   = cur_pc + 4;
        @(posedge clk);
        inst_valid <= 1'b1;
        inst       <= burst[k];
        @(negedge clk);
        if (k > 0) begin
            check_retire("burst retire", retire, make_retire(burst[k-1], 1'b1,
                         64'(99 + k), burst[k-1].pc + 4));
        end
    end
    @(posedge clk);
    inst_valid <= 1'b0;
    @(negedge clk);
    check_retire("burst retire", retire, make_retire(burst[3], 1'b1, 64'd103,
                 burst[3].pc + 4));
    @(negedge clk);
    if (retire.valid !== 1'b0) begin
        error_count++;
        $display("ERROR %0t: retire pulse after an idle cycle", $time);
    end
    finish_test("back to back", errs);
endtask

// ==== tests/exec_unit_tb.sv ====
`timescale 1ns/1ps

module exec_unit_tb
    import exu_pkg::*;
;

    localparam int CYCLE_LIMIT = 2000;

    logic       clk = 1'b0;
    logic       reset;
    logic       inst_valid;
    exec_inst_t inst;
    xlen_t      mem_rdata;
    mem_req_t   mem_req;
    xlen_t      next_pc;
    retire_t    retire;

    xlen_t  mem_words [32];
    xlen_t  model_regs [REG_COUNT];
    xlen_t  cur_pc = 64'h1000;
    integer seed = 27743;
    int     error_count = 0;
    int     check_count = 0;
    int     test_count = 0;
    int     cycles = 0;

    exec_unit uut (
        .clk        (clk),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst       (inst),
        .mem_rdata  (mem_rdata),
        .mem_req    (mem_req),
        .next_pc    (next_pc),
        .retire     (retire)
    );

    always #10 clk = ~clk;

    // 256-byte memory, doubleword read port
    assign mem_rdata = mem_words[mem_req.addr[7:3]];

    always @(posedge clk) begin
        if (mem_req.write_en) begin
            for (int b = 0; b < 8; b++) begin
                if (mem_req.wmask[b]) begin
                    mem_words[mem_req.addr[7:3]][8*b +: 8] <= mem_req.wdata[8*b +: 8];
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the run went past %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    task automatic check_xlen(input string what, input xlen_t got, input xlen_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_mem_req(input string what, input mem_req_t got, input mem_req_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERROR %0t: %s got r%b w%b addr %h data %h mask %h", $time, what,
                     got.read_en, got.write_en, got.addr, got.wdata, got.wmask);
            $display("ERROR %0t: %s expected r%b w%b addr %h data %h mask %h", $time, what,
                     exp.read_en, exp.write_en, exp.addr, exp.wdata, exp.wmask);
        end
    endtask

    task automatic check_retire(input string what, input retire_t got, input retire_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERROR %0t: %s got v%b rd %0d wen %b data %h pc %h npc %h", $time, what,
                     got.valid, got.rd, got.wen, got.data, got.pc, got.next_pc);
            $display("ERROR %0t: %s expected v%b rd %0d wen %b data %h pc %h npc %h", $time,
                     what, exp.valid, exp.rd, exp.wen, exp.data, exp.pc, exp.next_pc);
        end
    endtask

    function automatic xlen_t widen32(input word_t w);
        xlen_t r;
        r = {{32{w[31]}}, w};
        return r;
    endfunction

    function automatic xlen_t rand64();
        xlen_t r;
        r[63:32] = $random(seed);
        r[31:0]  = $random(seed);
        return r;
    endfunction

    // reference results straight from the ISA rules
    function automatic xlen_t expect_result(input exec_op_t op, input xlen_t a, input xlen_t b);
        word_t aw;
        word_t bw;
        word_t w;
        aw = a[31:0];
        bw = b[31:0];
        case (op)
            ADD:  return a + b;
            SUB:  return a - b;
            SLL:  return a << b[5:0];
            SRL:  return a >> b[5:0];
            SRA:  return $signed(a) >>> b[5:0];
            AND:  return a & b;
            OR:   return a | b;
            XOR:  return a ^ b;
            SLT:  return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            SLTU: return (a < b) ? 64'd1 : 64'd0;
            ADDW: return widen32(aw + bw);
            SUBW: return widen32(aw - bw);
            SLLW: return widen32(aw << b[4:0]);
            SRLW: return widen32(aw >> b[4:0]);
            SRAW: begin
                w = $signed(aw) >>> b[4:0];
                return widen32(w);
            end
            MUL:  return a * b;
            MULW: begin
                w = aw * bw;
                return widen32(w);
            end
            DIVU: return (b == 0) ? '1 : a / b;
            REMU: return (b == 0) ? a : a % b;
            DIVW, REMW: begin
                if (bw == 0) begin
                    w = (op == DIVW) ? 32'hffff_ffff : aw;
                end else if (aw == 32'h8000_0000 && bw == 32'hffff_ffff) begin
                    w = (op == DIVW) ? aw : 32'd0;
                end else begin
                    w = (op == DIVW) ? $signed(aw) / $signed(bw) : $signed(aw) % $signed(bw);
                end
                return widen32(w);
            end
            default: return '0;
        endcase
    endfunction

    function automatic xlen_t expect_load(input exec_op_t op, input xlen_t addr);
        xlen_t w;
        w = mem_words[addr[7:3]] >> (8 * addr[2:0]);
        case (op)
            LB:      return {{56{w[7]}}, w[7:0]};
            LBU:     return {56'd0, w[7:0]};
            LH:      return {{48{w[15]}}, w[15:0]};
            LHU:     return {48'd0, w[15:0]};
            LW:      return widen32(w[31:0]);
            LWU:     return {32'd0, w[31:0]};
            default: return w;
        endcase
    endfunction

    function automatic exec_inst_t make_inst(input exec_op_t op, input reg_idx_t rd,
                                             input reg_idx_t rs1, input reg_idx_t rs2,
                                             input logic use_imm, input xlen_t imm);
        exec_inst_t i;
        i.op      = op;
        i.use_imm = use_imm;
        i.rd      = rd;
        i.rs1     = rs1;
        i.rs2     = rs2;
        i.imm     = imm;
        i.pc      = cur_pc;
        return i;
    endfunction

    function automatic retire_t make_retire(input exec_inst_t i, input logic wen,
                                            input xlen_t data, input xlen_t npc);
        retire_t r;
        r.valid   = 1'b1;
        r.rd      = i.rd;
        r.wen     = wen;
        r.data    = data;
        r.pc      = i.pc;
        r.next_pc = npc;
        return r;
    endfunction

    // one instruction, sampled mid-cycle, then wait for its retire pulse
    task automatic run_inst(input exec_inst_t i, output mem_req_t req, output xlen_t npc,
                            output retire_t ret);
        int waited;
        @(posedge clk);
        inst_valid <= 1'b1;
        inst       <= i;
        @(negedge clk);
        req = mem_req;
        npc = next_pc;
        @(posedge clk);
        inst_valid <= 1'b0;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!retire.valid && waited < 4);
        ret = retire;
        if (!retire.valid) begin
            error_count++;
            $display("no retire pulse came for the instruction at pc %h", i.pc);
        end
        cur_pc = cur_pc + 4;
    endtask

    // loads a register through LD from its own doubleword slot
    task automatic set_reg(input reg_idx_t idx, input xlen_t value);
        exec_inst_t i;
        mem_req_t   req;
        xlen_t      npc;
        retire_t    ret;
        mem_words[idx] = value;
        i = make_inst(LD, idx, 5'd0, 5'd0, 1'b1, 64'(idx) * 8);
        run_inst(i, req, npc, ret);
        check_xlen("register load", ret.data, value);
        model_regs[idx] = value;
    endtask

    task automatic finish_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, error_count - errors_before);
        end
    endtask

    `include "exec_unit_tests.svh"

    initial begin
        reset      = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        for (int a = 0; a < 32; a++) begin
            for (int b = 0; b < 8; b++) begin
                mem_words[a][8*b +: 8] = 8'((a * 8 + b) * 7 + 3);
            end
        end
        foreach (model_regs[r]) begin
            model_regs[r] = '0;
        end
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        test_reset();
        test_alu();
        test_mul_div();
        test_load_store();
        test_branch_jump();
        test_back_to_back();
        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+tests
rtl/exu_pkg.sv
rtl/reg_file.sv
rtl/int_alu.sv
rtl/mul_div_unit.sv
rtl/load_store_unit.sv
rtl/result_select.sv
rtl/exec_unit.sv
tests/exec_unit_tb.sv
